// ==== src/sb_pkg.sv ====
package sb_pkg;

    // debug register address width, part of dm_req_t
    localparam int DM_ABITS = 7;

    localparam int SB_ADDR_W = 32;
    localparam int SB_DATA_W = 32;
    localparam int AXI_ID_W = 4;

    // debug register offsets
    localparam logic [DM_ABITS-1:0] SBCS_ADDR = 7'h38;
    localparam logic [DM_ABITS-1:0] SBADDRESS0_ADDR = 7'h39;
    localparam logic [DM_ABITS-1:0] SBDATA0_ADDR = 7'h3C;

    // sbaccess encoding, also used as AXI size
    typedef enum logic [2:0] {
        SB_BYTE = 3'd0,
        SB_HALF = 3'd1,
        SB_WORD = 3'd2
    } sb_access_e;

    typedef enum logic [2:0] {
        SB_ERR_NONE = 3'd0,
        SB_ERR_BUS = 3'd2,   // bus returned an error response
        SB_ERR_ALIGN = 3'd3,
        SB_ERR_SIZE = 3'd4
    } sb_error_e;

    typedef struct packed {
        logic wen;
        logic ren;
        logic [DM_ABITS-1:0] addr;
        logic [31:0] data;
    } dm_req_t;

    // field order matches sbcs[20:15]
    typedef struct packed {
        logic readonaddr;
        sb_access_e access;
        logic autoincrement;
        logic readondata;
    } sb_ctrl_t;

    // common to AW and AR
    typedef struct packed {
        logic [AXI_ID_W-1:0] id;
        logic [SB_ADDR_W-1:0] addr;
        logic [2:0] size;
    } sb_axi_addr_t;

    typedef struct packed {
        logic [SB_DATA_W-1:0] data;
        logic [SB_DATA_W/8-1:0] strb;
    } sb_axi_w_t;

    typedef struct packed {
        logic [AXI_ID_W-1:0] id;
        logic [1:0] resp;
    } sb_axi_b_t;

    typedef struct packed {
        logic [AXI_ID_W-1:0] id;
        logic [1:0] resp;
        logic [SB_DATA_W-1:0] data;
        logic last;
    } sb_axi_r_t;

endpackage

// ==== src/sb_access_ctrl.sv ====
`timescale 1ns/1ps

module sb_access_ctrl (
    input  logic                 dm_clk,
    input  logic                 dm_rst_n,
    input  logic                 dmactive,
    input  logic                 busy,
    input  logic                 done_err,
    input  logic [1:0]           addr_lsb,
    input  sb_pkg::dm_req_t      dm_req,
    output sb_pkg::sb_ctrl_t     ctrl,
    output logic                 busyerror,
    output sb_pkg::sb_error_e    sberror,
    output logic                 addr_wen,
    output logic                 data_wen,
    output logic                 start_write,
    output logic                 start_read
);

    import sb_pkg::*;

    localparam sb_ctrl_t CTRL_RST = '{
        readonaddr: 1'b0,
        access: SB_WORD,
        autoincrement: 1'b0,
        readondata: 1'b0
    };

    logic sel_sbcs;
    logic sel_addr;
    logic sel_data;
    logic sbcs_wen;
    logic data_ren;
    logic busy_access;
    logic req_write;
    logic req_read;
    logic can_start;
    logic trigger;
    logic size_ok;
    logic misalign;
    logic [1:0] chk_lsb;

    function automatic logic is_misaligned(sb_access_e acc, logic [1:0] lsb);
        case (acc)
            SB_HALF: return lsb[0];
            SB_WORD: return |lsb;
            default: return 1'b0;
        endcase
    endfunction

    assign sel_sbcs = (dm_req.addr == SBCS_ADDR);
    assign sel_addr = (dm_req.addr == SBADDRESS0_ADDR);
    assign sel_data = (dm_req.addr == SBDATA0_ADDR);

    // register writes are dropped while a transfer is running
    assign sbcs_wen = dm_req.wen & sel_sbcs & ~busy;
    assign addr_wen = dm_req.wen & sel_addr & ~busy;
    assign data_wen = dm_req.wen & sel_data & ~busy;
    assign data_ren = dm_req.ren & sel_data;

    assign busy_access = busy & (sel_addr | sel_data) & (dm_req.wen | dm_req.ren);

    assign req_write = data_wen;
    assign req_read = ((addr_wen & ctrl.readonaddr) | (data_ren & ctrl.readondata)) & ~req_write;

    assign chk_lsb = addr_wen ? dm_req.data[1:0] : addr_lsb; // new address on sbaddress0 write
    assign size_ok = (ctrl.access == SB_BYTE) | (ctrl.access == SB_HALF) |
                     (ctrl.access == SB_WORD);
    assign misalign = is_misaligned(ctrl.access, chk_lsb);

    assign can_start = dmactive & ~busy & ~busyerror & (sberror == SB_ERR_NONE);
    assign trigger = can_start & (req_write | req_read);

    assign start_write = trigger & req_write & size_ok & ~misalign;
    assign start_read = trigger & req_read & size_ok & ~misalign;

    always_ff @(posedge dm_clk or negedge dm_rst_n) begin
        if (!dm_rst_n) begin
            ctrl <= CTRL_RST;
            busyerror <= 1'b0;
            sberror <= SB_ERR_NONE;
        end else if (!dmactive) begin
            ctrl <= CTRL_RST;
            busyerror <= 1'b0;
            sberror <= SB_ERR_NONE;
        end else begin
            if (sbcs_wen) begin
                ctrl.readonaddr <= dm_req.data[20];
                ctrl.access <= sb_access_e'(dm_req.data[19:17]);
                ctrl.autoincrement <= dm_req.data[16];
                ctrl.readondata <= dm_req.data[15];
            end

            if (sbcs_wen && dm_req.data[22]) begin
                busyerror <= 1'b0; // w1c
            end else if (busy_access) begin
                busyerror <= 1'b1;
            end

            if (sbcs_wen) begin
                sberror <= sb_error_e'(sberror & ~dm_req.data[14:12]);
            end else if (trigger && !size_ok) begin
                sberror <= SB_ERR_SIZE;
            end else if (trigger && misalign) begin
                sberror <= SB_ERR_ALIGN;
            end else if (done_err) begin
                sberror <= SB_ERR_BUS;
            end
        end
    end

endmodule

// ==== src/sb_addr_data.sv ====
`timescale 1ns/1ps

module sb_addr_data (
    input  logic                 dm_clk,
    input  logic                 dm_rst_n,
    input  logic                 dmactive,
    input  logic                 addr_wen,
    input  logic                 data_wen,
    input  logic                 done_ok,
    input  logic                 is_read,
    input  sb_pkg::sb_ctrl_t     ctrl,
    input  logic [31:0]          wr_data,
    input  logic [31:0]          load_data,
    output logic [31:0]          sbaddress0,
    output logic [31:0]          sbdata0
);

    import sb_pkg::*;

    logic [31:0] incr;

    always_comb begin
        case (ctrl.access)
            SB_BYTE: incr = 32'd1;
            SB_HALF: incr = 32'd2;
            SB_WORD: incr = 32'd4;
            default: incr = 32'd0;
        endcase
    end

    always_ff @(posedge dm_clk or negedge dm_rst_n) begin
        if (!dm_rst_n) begin
            sbaddress0 <= '0;
        end else if (!dmactive) begin
            sbaddress0 <= '0;
        end else if (addr_wen) begin
            sbaddress0 <= wr_data;
        end else if (done_ok && ctrl.autoincrement) begin
            sbaddress0 <= sbaddress0 + incr; // only on a good response
        end
    end

    always_ff @(posedge dm_clk or negedge dm_rst_n) begin
        if (!dm_rst_n) begin
            sbdata0 <= '0;
        end else if (!dmactive) begin
            sbdata0 <= '0;
        end else if (data_wen) begin
            sbdata0 <= wr_data;
        end else if (done_ok && is_read) begin
            sbdata0 <= load_data;
        end
    end

endmodule

// ==== src/sb_lane_align.sv ====
`timescale 1ns/1ps

module sb_lane_align (
    input  sb_pkg::sb_access_e   access,
    input  logic [1:0]           addr_lsb,
    input  logic [31:0]          store_data,
    input  logic [31:0]          rdata,
    output sb_pkg::sb_axi_w_t    w_beat,
    output logic [31:0]          load_data
);

    import sb_pkg::*;

    logic [4:0] shamt;
    logic [SB_DATA_W/8-1:0] size_mask;
    logic [31:0] data_mask;
    logic [31:0] rdata_shifted;

    assign shamt = {addr_lsb, 3'b000}; // byte offset in bits

    always_comb begin
        case (access)
            SB_BYTE: begin
                size_mask = 4'b0001;
                data_mask = 32'h0000_00ff;
            end
            SB_HALF: begin
                size_mask = 4'b0011;
                data_mask = 32'h0000_ffff;
            end
            SB_WORD: begin
                size_mask = 4'b1111;
                data_mask = 32'hffff_ffff;
            end
            default: begin
                size_mask = 4'b0000;
                data_mask = 32'h0000_0000;
            end
        endcase
    end

    assign w_beat.data = store_data << shamt;
    assign w_beat.strb = size_mask << addr_lsb;

    // zero-extended, no sign handling on the system bus
    assign rdata_shifted = rdata >> shamt;
    assign load_data = rdata_shifted & data_mask;

endmodule

// ==== src/sb_axi_master.sv ====
`timescale 1ns/1ps

module sb_axi_master #(
    parameter int AXI_ID = 3
) (
    input  logic                   dm_clk,
    input  logic                   dm_rst_n,
    input  logic                   start_write,
    input  logic                   start_read,
    input  sb_pkg::sb_access_e     access,
    input  logic [31:0]            addr,
    input  sb_pkg::sb_axi_w_t      w_beat,
    output sb_pkg::sb_axi_addr_t   aw,
    output logic                   awvalid,
    input  logic                   awready,
    output sb_pkg::sb_axi_w_t      w,
    output logic                   wvalid,
    input  logic                   wready,
    input  sb_pkg::sb_axi_b_t      b,
    input  logic                   bvalid,
    output sb_pkg::sb_axi_addr_t   ar,
    output logic                   arvalid,
    input  logic                   arready,
    input  sb_pkg::sb_axi_r_t      r,
    input  logic                   rvalid,
    output logic                   busy,
    output logic                   done_ok,
    output logic                   done_err,
    output logic                   is_read
);

    import sb_pkg::*;

    localparam logic [AXI_ID_W-1:0] MY_ID = AXI_ID_W'(AXI_ID);

    typedef enum logic [2:0] {
        ST_IDLE, ST_WAIT_AR, ST_WAIT_R, ST_WAIT_AW_W, ST_WAIT_AW, ST_WAIT_W, ST_WAIT_B
    } state_e;

    state_e state;
    logic aw_hs;
    logic w_hs;
    logic ar_hs;
    logic b_hit;
    logic r_hit;

    assign aw_hs = awvalid & awready;
    assign w_hs = wvalid & wready;
    assign ar_hs = arvalid & arready;
    assign b_hit = bvalid & (b.id == MY_ID) & (state == ST_WAIT_B); // other ids ignored
    assign r_hit = rvalid & r.last & (r.id == MY_ID) & (state == ST_WAIT_R);

    always_ff @(posedge dm_clk or negedge dm_rst_n) begin
        if (!dm_rst_n) begin
            state <= ST_IDLE;
            awvalid <= 1'b0;
            wvalid <= 1'b0;
            arvalid <= 1'b0;
        end else begin
            if (aw_hs) awvalid <= 1'b0;
            if (w_hs) wvalid <= 1'b0;
            if (ar_hs) arvalid <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (start_write) begin
                        state <= ST_WAIT_AW_W;
                        awvalid <= 1'b1;
                        wvalid <= 1'b1;
                    end else if (start_read) begin
                        state <= ST_WAIT_AR;
                        arvalid <= 1'b1;
                    end
                end
                ST_WAIT_AR: if (ar_hs) state <= ST_WAIT_R;
                ST_WAIT_R: if (r_hit) state <= ST_IDLE;
                ST_WAIT_AW_W: begin
                    if (aw_hs && w_hs) state <= ST_WAIT_B;
                    else if (w_hs) state <= ST_WAIT_AW;
                    else if (aw_hs) state <= ST_WAIT_W;
                end
                ST_WAIT_AW: if (aw_hs) state <= ST_WAIT_B;
                ST_WAIT_W: if (w_hs) state <= ST_WAIT_B;
                ST_WAIT_B: if (b_hit) state <= ST_IDLE;
                default: state <= ST_IDLE;
            endcase
        end
    end

    assign aw = '{id: MY_ID, addr: addr, size: access};
    assign ar = aw;
    assign w = w_beat;

    assign busy = (state != ST_IDLE);
    assign is_read = (state == ST_WAIT_R);
    assign done_ok = (b_hit & (b.resp == 2'b00)) | (r_hit & (r.resp == 2'b00));
    assign done_err = (b_hit & (b.resp != 2'b00)) | (r_hit & (r.resp != 2'b00));

endmodule

// ==== src/dm_systembus.sv ====
`timescale 1ns/1ps

module dm_systembus #(
    parameter int AXI_ID = 3
) (
    input  logic                   dm_clk,
    input  logic                   dm_rst_n,
    input  logic                   dmactive,
    input  sb_pkg::dm_req_t        dm_req,
    output logic [31:0]            sbcs,
    output logic [31:0]            sbaddress0,
    output logic [31:0]            sbdata0,
    output sb_pkg::sb_axi_addr_t   aw,
    output logic                   awvalid,
    input  logic                   awready,
    output sb_pkg::sb_axi_w_t      w,
    output logic                   wvalid,
    input  logic                   wready,
    input  sb_pkg::sb_axi_b_t      b,
    input  logic                   bvalid,
    output sb_pkg::sb_axi_addr_t   ar,
    output logic                   arvalid,
    input  logic                   arready,
    input  sb_pkg::sb_axi_r_t      r,
    input  logic                   rvalid
);

    import sb_pkg::*;

    sb_ctrl_t ctrl;
    sb_error_e sberror;
    sb_axi_w_t w_beat;
    logic busyerror;
    logic busy;
    logic addr_wen;
    logic data_wen;
    logic start_write;
    logic start_read;
    logic done_ok;
    logic done_err;
    logic is_read;
    logic [31:0] load_data;

    sb_access_ctrl i_access_ctrl (
        .dm_clk, .dm_rst_n, .dmactive, .busy, .done_err,
        .addr_lsb(sbaddress0[1:0]), .dm_req, .ctrl, .busyerror, .sberror,
        .addr_wen, .data_wen, .start_write, .start_read
    );

    sb_addr_data i_addr_data (
        .dm_clk, .dm_rst_n, .dmactive, .addr_wen, .data_wen, .done_ok, .is_read,
        .ctrl, .wr_data(dm_req.data), .load_data, .sbaddress0, .sbdata0
    );

    sb_lane_align i_lane_align (
        .access(ctrl.access), .addr_lsb(sbaddress0[1:0]), .store_data(sbdata0),
        .rdata(r.data), .w_beat, .load_data
    );

    sb_axi_master #(.AXI_ID(AXI_ID)) i_axi_master (
        .dm_clk, .dm_rst_n, .start_write, .start_read, .access(ctrl.access),
        .addr(sbaddress0), .w_beat, .aw, .awvalid, .awready, .w, .wvalid, .wready,
        .b, .bvalid, .ar, .arvalid, .arready, .r, .rvalid,
        .busy, .done_ok, .done_err, .is_read
    );

    // sbversion 1, asize 32, byte/half/word supported
    assign sbcs = {3'd1, 6'd0, busyerror, busy, ctrl, sberror, 7'd32, 2'b00, 3'b111};

endmodule

// ==== verification/tb_axi_mem.sv ====
`timescale 1ns/1ps

module tb_axi_mem #(
    parameter int RESP_ID = 3,
    parameter logic [31:0] ERR_BASE = 32'h0000_0800
) (
    input  logic                   dm_clk,
    input  logic                   dm_rst_n,
    input  logic                   stall,      // holds every ready low
    input  sb_pkg::sb_axi_addr_t   aw,
    input  logic                   awvalid,
    output logic                   awready,
    input  sb_pkg::sb_axi_w_t      w,
    input  logic                   wvalid,
    output logic                   wready,
    output sb_pkg::sb_axi_b_t      b,
    output logic                   bvalid,
    input  sb_pkg::sb_axi_addr_t   ar,
    input  logic                   arvalid,
    output logic                   arready,
    output sb_pkg::sb_axi_r_t      r,
    output logic                   rvalid
);

    import sb_pkg::*;

    logic [31:0] mem [256];
    sb_axi_addr_t aw_q;
    sb_axi_w_t w_q;
    logic aw_got;
    logic w_got;
    int seed = 85655;

    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = {i[7:0] ^ 8'hc3, i[7:0], ~i[7:0], i[7:0] + 8'h3c};
        end
    end

    always @(posedge dm_clk or negedge dm_rst_n) begin
        if (!dm_rst_n) begin
            awready <= 1'b0;
            wready <= 1'b0;
            arready <= 1'b0;
            bvalid <= 1'b0;
            rvalid <= 1'b0;
            aw_got <= 1'b0;
            w_got <= 1'b0;
            b <= '0;
            r <= '0;
        end else begin
            awready <= !stall && (($random(seed) & 3) != 0);
            wready <= !stall && (($random(seed) & 3) != 0);
            arready <= !stall && (($random(seed) & 3) != 0);
            bvalid <= 1'b0; // master is always ready
            rvalid <= 1'b0;
            if (awvalid && awready) begin
                aw_q <= aw;
                aw_got <= 1'b1;
            end
            if (wvalid && wready) begin
                w_q <= w;
                w_got <= 1'b1;
            end
            if (aw_got && w_got) begin
                aw_got <= 1'b0;
                w_got <= 1'b0;
                bvalid <= 1'b1;
                b.id <= AXI_ID_W'(RESP_ID);
                b.resp <= (aw_q.addr >= ERR_BASE) ? 2'b10 : 2'b00;
                for (int i = 0; i < 4; i++) begin
                    if (w_q.strb[i] && aw_q.addr < ERR_BASE) begin
                        mem[aw_q.addr[9:2]][8*i +: 8] <= w_q.data[8*i +: 8];
                    end
                end
            end
            if (arvalid && arready) begin
                rvalid <= 1'b1;
                r.id <= AXI_ID_W'(RESP_ID);
                r.resp <= (ar.addr >= ERR_BASE) ? 2'b10 : 2'b00; // slverr above the limit
                r.data <= mem[ar.addr[9:2]];
                r.last <= 1'b1;
            end
        end
    end

endmodule

// ==== verification/tb_dm_systembus.sv ====
`timescale 1ns/1ps

module tb_dm_systembus;

    import sb_pkg::*;

    localparam int BUS_ID = 3;

    typedef enum logic [2:0] {
        OP_WR, OP_RD, OP_MEM, OP_NOBUS, OP_BUSYWR, OP_DMCLR
    } op_e;

    typedef struct packed {
        op_e op;
        logic [DM_ABITS-1:0] regaddr;
        logic [31:0] data;   // memory address for OP_MEM
        logic [31:0] exp;    // second write data for OP_BUSYWR
    } step_t;

    logic dm_clk;
    logic dm_rst_n;
    logic dmactive;
    logic stall;
    dm_req_t dm_req;
    logic [31:0] sbcs;
    logic [31:0] sbaddress0;
    logic [31:0] sbdata0;
    sb_axi_addr_t aw;
    sb_axi_addr_t ar;
    sb_axi_w_t w;
    sb_axi_b_t b;
    sb_axi_r_t r;
    logic awvalid;
    logic awready;
    logic wvalid;
    logic wready;
    logic bvalid;
    logic arvalid;
    logic arready;
    logic rvalid;
    logic [2:0] exp_size;

    step_t steps[$];
    int errors = 0;
    int checks = 0;
    int bus_txns = 0;
    int cycles = 0;
    int limit = 0;
    int step_idx = 0;

    dm_systembus #(.AXI_ID(BUS_ID)) i_dut (
        .dm_clk, .dm_rst_n, .dmactive, .dm_req, .sbcs, .sbaddress0, .sbdata0,
        .aw, .awvalid, .awready, .w, .wvalid, .wready, .b, .bvalid,
        .ar, .arvalid, .arready, .r, .rvalid
    );

    tb_axi_mem #(.RESP_ID(BUS_ID)) i_mem (
        .dm_clk, .dm_rst_n, .stall, .aw, .awvalid, .awready, .w, .wvalid, .wready,
        .b, .bvalid, .ar, .arvalid, .arready, .r, .rvalid
    );

    initial begin
        dm_clk = 1'b0;
        forever #10 dm_clk = ~dm_clk;
    end

    always @(posedge dm_clk) begin
        if ((awvalid && awready) || (arvalid && arready)) begin
            bus_txns <= bus_txns + 1;
        end
        if (awvalid && awready) begin
            check_request("AW", aw);
        end
        if (arvalid && arready) begin
            check_request("AR", ar);
        end
    end

    // sbcs as laid out by the debug spec with busy at 0
    function automatic logic [31:0] sbcs_fields(logic be, logic roa, logic [2:0] acc,
                                                logic ai, logic rod, logic [2:0] err);
        return 32'h2000_0407 | (32'(be) << 22) | (32'(roa) << 20) | (32'(acc) << 17) |
               (32'(ai) << 16) | (32'(rod) << 15) | (32'(err) << 12);
    endfunction

    function automatic logic [31:0] reg_value(logic [DM_ABITS-1:0] regaddr);
        case (regaddr)
            SBCS_ADDR: return sbcs;
            SBADDRESS0_ADDR: return sbaddress0;
            default: return sbdata0;
        endcase
    endfunction

    task automatic add_step(op_e op, logic [DM_ABITS-1:0] regaddr, logic [31:0] data,
                            logic [31:0] exp);
        step_t s;
        s.op = op;
        s.regaddr = regaddr;
        s.data = data;
        s.exp = exp;
        steps.push_back(s);
    endtask

    task automatic add_store(logic [31:0] addr, logic [31:0] data, logic [31:0] mem_word);
        add_step(OP_WR, SBADDRESS0_ADDR, addr, 0);
        add_step(OP_WR, SBDATA0_ADDR, data, 0);
        add_step(OP_MEM, 0, addr, mem_word);
    endtask

    task automatic check_value(string what, logic [31:0] got, logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("FAIL at %0d ns: step %0d, %s: got %08h, expected %08h",
                     $time, step_idx, what, got, exp);
        end
    endtask

    task automatic check_request(string chan, sb_axi_addr_t req);
        check_value({chan, " id"}, 32'(req.id), 32'(BUS_ID));
        check_value({chan, " size"}, 32'(req.size), 32'(exp_size));
    endtask

    task automatic write_reg(logic [DM_ABITS-1:0] regaddr, logic [31:0] data);
        dm_req.wen = 1'b1;
        dm_req.ren = 1'b0;
        dm_req.addr = regaddr;
        dm_req.data = data;
        @(negedge dm_clk);
        dm_req = '0;
    endtask

    task automatic read_check(logic [DM_ABITS-1:0] regaddr, logic [31:0] exp);
        logic [31:0] value;
        value = reg_value(regaddr); // level before the read strobe
        dm_req.wen = 1'b0;
        dm_req.ren = 1'b1;
        dm_req.addr = regaddr;
        dm_req.data = '0;
        @(negedge dm_clk);
        dm_req = '0;
        check_value($sformatf("register %02h", regaddr), value, exp);
    endtask

    task automatic wait_idle();
        while (sbcs[21]) begin
            @(negedge dm_clk);
        end
    endtask

    task automatic run_step(step_t s);
        int txns_before;
        case (s.op)
            OP_WR: begin
                write_reg(s.regaddr, s.data);
                if (s.regaddr == SBCS_ADDR) begin
                    exp_size = s.data[19:17]; // new sbaccess
                end
            end
            OP_RD: read_check(s.regaddr, s.exp);
            OP_MEM: check_value("memory word", i_mem.mem[s.data[9:2]], s.exp);
            OP_NOBUS: begin
                txns_before = bus_txns;
                write_reg(s.regaddr, s.data);
                repeat (4) @(negedge dm_clk);
                check_value("bus transactions", 32'(bus_txns), 32'(txns_before));
            end
            OP_BUSYWR: begin
                stall = 1'b1;
                write_reg(SBDATA0_ADDR, s.data);
                repeat (3) @(negedge dm_clk);
                check_value("sbcs busy", 32'(sbcs[21]), 32'd1);
                write_reg(SBDATA0_ADDR, s.exp); // lands while busy
                stall = 1'b0;
            end
            default: begin
                dmactive = 1'b0;
                @(negedge dm_clk);
                dmactive = 1'b1;
                exp_size = SB_WORD;
            end
        endcase
    endtask

    task automatic build_table();
        add_step(OP_RD, SBCS_ADDR, 0, 32'h2004_0407);
        add_step(OP_RD, SBADDRESS0_ADDR, 0, 0);
        add_step(OP_RD, SBDATA0_ADDR, 0, 0);
        add_step(OP_WR, SBCS_ADDR, sbcs_fields(0, 0, SB_WORD, 0, 0, 0), 0);
        add_store(32'h100, 32'h1122_3344, 32'h1122_3344);
        add_step(OP_WR, SBCS_ADDR, sbcs_fields(0, 0, SB_BYTE, 0, 0, 0), 0);
        add_store(32'h101, 32'h0000_00aa, 32'h1122_aa44);
        add_store(32'h100, 32'h0000_0055, 32'h1122_aa55);
        add_store(32'h102, 32'hffff_ff66, 32'h1166_aa55);
        add_store(32'h103, 32'h0000_0077, 32'h7766_aa55);
        add_step(OP_WR, SBCS_ADDR, sbcs_fields(0, 0, SB_HALF, 0, 0, 0), 0);
        add_store(32'h100, 32'h0000_beef, 32'h7766_beef);
        add_store(32'h102, 32'h1234_cafe, 32'hcafe_beef);
        // word stores with autoincrement
        add_step(OP_WR, SBCS_ADDR, sbcs_fields(0, 0, SB_WORD, 1, 0, 0), 0);
        add_step(OP_WR, SBADDRESS0_ADDR, 32'h104, 0);
        add_step(OP_WR, SBDATA0_ADDR, 32'h89ab_cdef, 0);
        add_step(OP_WR, SBDATA0_ADDR, 32'h0123_4567, 0);
        add_step(OP_RD, SBADDRESS0_ADDR, 0, 32'h10c);
        add_step(OP_MEM, 0, 32'h104, 32'h89ab_cdef);
        add_step(OP_MEM, 0, 32'h108, 32'h0123_4567);
        // reads on address and on data
        add_step(OP_WR, SBCS_ADDR, sbcs_fields(0, 1, SB_BYTE, 1, 1, 0), 0);
        add_step(OP_WR, SBADDRESS0_ADDR, 32'h100, 0);
        add_step(OP_RD, SBDATA0_ADDR, 0, 32'h0000_00ef);
        add_step(OP_RD, SBDATA0_ADDR, 0, 32'h0000_00be);
        add_step(OP_RD, SBADDRESS0_ADDR, 0, 32'h103);
        add_step(OP_WR, SBCS_ADDR, sbcs_fields(0, 1, SB_HALF, 1, 1, 0), 0);
        add_step(OP_WR, SBADDRESS0_ADDR, 32'h102, 0);
        add_step(OP_RD, SBDATA0_ADDR, 0, 32'h0000_cafe);
        add_step(OP_RD, SBDATA0_ADDR, 0, 32'h0000_cdef);
        add_step(OP_RD, SBADDRESS0_ADDR, 0, 32'h108);
        add_step(OP_WR, SBCS_ADDR, sbcs_fields(0, 1, SB_WORD, 1, 1, 0), 0);
        add_step(OP_WR, SBADDRESS0_ADDR, 32'h104, 0);
        add_step(OP_RD, SBDATA0_ADDR, 0, 32'h89ab_cdef);
        add_step(OP_WR, SBCS_ADDR, sbcs_fields(0, 1, SB_WORD, 1, 0, 0), 0);
        add_step(OP_RD, SBDATA0_ADDR, 0, 32'h0123_4567);
        add_step(OP_RD, SBADDRESS0_ADDR, 0, 32'h10c);
        // alignment and size errors
        add_step(OP_WR, SBCS_ADDR, sbcs_fields(0, 0, SB_HALF, 0, 0, 0), 0);
        add_step(OP_WR, SBADDRESS0_ADDR, 32'h101, 0);
        add_step(OP_NOBUS, SBDATA0_ADDR, 32'h1234, 0);
        add_step(OP_RD, SBCS_ADDR, 0, sbcs_fields(0, 0, SB_HALF, 0, 0, SB_ERR_ALIGN));
        add_step(OP_WR, SBADDRESS0_ADDR, 32'h100, 0);
        add_step(OP_NOBUS, SBDATA0_ADDR, 32'h5555, 0);
        add_step(OP_MEM, 0, 32'h100, 32'hcafe_beef);
        add_step(OP_WR, SBCS_ADDR, sbcs_fields(0, 0, SB_HALF, 0, 0, 3'b111), 0);
        add_step(OP_RD, SBCS_ADDR, 0, sbcs_fields(0, 0, SB_HALF, 0, 0, 0));
        add_step(OP_WR, SBCS_ADDR, sbcs_fields(0, 0, 3'd3, 0, 0, 0), 0);
        add_step(OP_NOBUS, SBDATA0_ADDR, 32'h1, 0);
        add_step(OP_RD, SBCS_ADDR, 0, sbcs_fields(0, 0, 3'd3, 0, 0, SB_ERR_SIZE));
        add_step(OP_WR, SBCS_ADDR, sbcs_fields(0, 0, SB_WORD, 1, 0, 3'b111), 0);
        add_step(OP_RD, SBCS_ADDR, 0, sbcs_fields(0, 0, SB_WORD, 1, 0, 0));
        // bus errors on a write and on a read
        add_step(OP_WR, SBADDRESS0_ADDR, 32'h800, 0);
        add_step(OP_WR, SBDATA0_ADDR, 32'hdead_beef, 0);
        add_step(OP_RD, SBCS_ADDR, 0, sbcs_fields(0, 0, SB_WORD, 1, 0, SB_ERR_BUS));
        add_step(OP_RD, SBADDRESS0_ADDR, 0, 32'h800);
        add_step(OP_WR, SBCS_ADDR, sbcs_fields(0, 1, SB_WORD, 1, 0, 3'b111), 0);
        add_step(OP_WR, SBADDRESS0_ADDR, 32'h904, 0);
        add_step(OP_RD, SBCS_ADDR, 0, sbcs_fields(0, 1, SB_WORD, 1, 0, SB_ERR_BUS));
        add_step(OP_RD, SBADDRESS0_ADDR, 0, 32'h904);
        add_step(OP_WR, SBCS_ADDR, sbcs_fields(0, 0, SB_WORD, 0, 0, 3'b111), 0);
        // busy error
        add_step(OP_WR, SBADDRESS0_ADDR, 32'h110, 0);
        add_step(OP_BUSYWR, SBDATA0_ADDR, 32'h0bad_f00d, 32'h5a5a_5a5a);
        add_step(OP_RD, SBCS_ADDR, 0, sbcs_fields(1, 0, SB_WORD, 0, 0, 0));
        add_step(OP_MEM, 0, 32'h110, 32'h0bad_f00d);
        add_step(OP_RD, SBDATA0_ADDR, 0, 32'h0bad_f00d);
        add_step(OP_NOBUS, SBDATA0_ADDR, 32'h1234_5678, 0);
        add_step(OP_WR, SBCS_ADDR, sbcs_fields(1, 0, SB_WORD, 0, 0, 0), 0);
        add_step(OP_RD, SBCS_ADDR, 0, 32'h2004_0407);
        // dmactive low clears everything
        add_step(OP_WR, SBCS_ADDR, sbcs_fields(0, 0, SB_HALF, 1, 1, 0), 0);
        add_step(OP_WR, SBADDRESS0_ADDR, 32'h1234, 0);
        add_step(OP_RD, SBCS_ADDR, 0, sbcs_fields(0, 0, SB_HALF, 1, 1, 0));
        add_step(OP_DMCLR, 0, 0, 0);
        add_step(OP_RD, SBCS_ADDR, 0, 32'h2004_0407);
        add_step(OP_RD, SBADDRESS0_ADDR, 0, 0);
        add_step(OP_RD, SBDATA0_ADDR, 0, 0);
    endtask

    initial begin
        dm_rst_n = 1'b0;
        dmactive = 1'b0;
        stall = 1'b0;
        dm_req = '0;
        exp_size = SB_WORD;
        build_table();
        limit = 60 * steps.size() + 100;
        repeat (10) @(posedge dm_clk);
        @(negedge dm_clk);
        dm_rst_n = 1'b1;
        dmactive = 1'b1;
        foreach (steps[i]) begin
            @(negedge dm_clk);
            wait_idle();
            step_idx = i;
            run_step(steps[i]);
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    initial begin
        wait (limit != 0);
        while (cycles < limit) begin
            @(posedge dm_clk);
            cycles++;
        end
        $display("timeout: the table did not finish within %0d clock cycles", limit);
        $display("checks: %0d, errors: %0d", checks, errors);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// ==== compile.f ====
src/sb_pkg.sv
src/sb_access_ctrl.sv
src/sb_addr_data.sv
src/sb_lane_align.sv
src/sb_axi_master.sv
src/dm_systembus.sv
verification/tb_axi_mem.sv
verification/tb_dm_systembus.sv

// ==== Bender.yml ====
package:
  name: dm_systembus

sources:
  - files:
      - src/sb_pkg.sv
      - src/sb_access_ctrl.sv
      - src/sb_addr_data.sv
      - src/sb_lane_align.sv
      - src/sb_axi_master.sv
      - src/dm_systembus.sv
  - target: test
    files:
      - verification/tb_axi_mem.sv
      - verification/tb_dm_systembus.sv
